// ==== flist.f ====
+incdir+.
merge_data_pkg.sv
merge_ctrl_pkg.sv
merge_fifo.sv
merge_control.sv
run_merger.sv
run_merger_props.sv
run_merger_tb.sv

// ==== merge_control.sv ====
`include "merge_defs.svh"

module merge_control (
   input  merge_data_pkg::head_view_t i_heads,
   input  merge_data_pkg::fifo_cnt_t  i_out_count,
   output merge_ctrl_pkg::merge_cmd_t o_cmd
);

   import merge_data_pkg::*;
   import merge_ctrl_pkg::*;

   // One output slot stays free for the word held in the data stage
   localparam fifo_cnt_t STALL_LVL = fifo_cnt_t'(`MERGE_FIFO_DEPTH - 1);
   localparam elem_t     RUN_END   = elem_t'(`MERGE_RUN_END);

   elem_t      head_a;
   elem_t      head_b;
   logic       a_end;
   logic       b_end;
   logic       a_le_b;
   logic       both_valid;
   logic       room;
   logic       go;
   logic       pick_b;
   merge_cmd_t cmd;

   assign head_a = i_heads.a_head;
   assign head_b = i_heads.b_head;

   // Terminator detect
   assign a_end = (head_a == RUN_END);
   assign b_end = (head_b == RUN_END);

   assign a_le_b = (head_a <= head_b);     // Ties go to A

   // Both heads must be known before any choice is made
   assign both_valid = i_heads.a_valid & i_heads.b_valid;
   assign room       = (i_out_count < STALL_LVL);
   assign go         = both_valid & room;

   // Which side supplies the next word
   always_comb begin
      case ({a_end, b_end})
         2'b11:   pick_b = 1'b0;           // Shared terminator from A
         2'b10:   pick_b = 1'b1;           // A run done
         2'b01:   pick_b = 1'b0;           // B run done
         default: pick_b = ~a_le_b;
      endcase
   end

   always_comb begin
      cmd = CMD_IDLE;
      if (go) begin
         cmd.emit   = 1'b1;
         cmd.take_b = pick_b;
         if (a_end && b_end) begin
            // Both runs closed, one zero out, drop both
            cmd.pop_a = 1'b1;
            cmd.pop_b = 1'b1;
         end else begin
            cmd.pop_a = ~pick_b;
            cmd.pop_b = pick_b;
         end
      end
   end

   assign o_cmd = cmd;

endmodule

// ==== merge_ctrl_pkg.sv ====
package merge_ctrl_pkg;

   // Decision for one cycle
   typedef struct packed {
      logic pop_a;         // Dequeue buffer A
      logic pop_b;         // Dequeue buffer B
      logic emit;          // Data stage captures a head
      logic take_b;        // Capture B head instead of A
   } merge_cmd_t;

   localparam merge_cmd_t CMD_IDLE = '{
      pop_a:  1'b0,
      pop_b:  1'b0,
      emit:   1'b0,
      take_b: 1'b0
   };

endpackage

// ==== merge_data_pkg.sv ====
`include "merge_defs.svh"

package merge_data_pkg;

   // One sort key
   typedef logic [`MERGE_DATA_W-1:0] elem_t;

   typedef logic [`MERGE_FIFO_AW-1:0] fifo_ptr_t;   // Slot index
   typedef logic [`MERGE_FIFO_AW:0]   fifo_cnt_t;   // Fill level up to full depth

   // What the control sees of the two input buffers
   typedef struct packed {
      elem_t a_head;
      elem_t b_head;
      logic  a_valid;      // Buffer A not empty
      logic  b_valid;      // Buffer B not empty
   } head_view_t;

endpackage

// ==== merge_defs.svh ====
`ifndef MERGE_DEFS_SVH
`define MERGE_DEFS_SVH

// Bits per sort key
`define MERGE_DATA_W 32

// Address bits of every internal FIFO
`define MERGE_FIFO_AW 4

// Entries per FIFO
`define MERGE_FIFO_DEPTH (1 << `MERGE_FIFO_AW)

// A key of zero never travels as payload.
// It closes a run on every input and on the output.
`define MERGE_RUN_END 0

`endif

// ==== merge_fifo.sv ====
`include "merge_defs.svh"

module merge_fifo (
   input  logic                      i_clk,
   input  logic                      i_rst_n,
   input  merge_data_pkg::elem_t     i_data,
   input  logic                      i_enq,
   input  logic                      i_deq,
   output merge_data_pkg::elem_t     o_data,
   output logic                      o_empty,
   output logic                      o_full,
   output merge_data_pkg::fifo_cnt_t o_count
);

   import merge_data_pkg::*;

   localparam int unsigned DEPTH = `MERGE_FIFO_DEPTH;

   elem_t     mem [DEPTH];
   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;
   fifo_cnt_t count;
   logic      do_enq;
   logic      do_deq;

   assign o_empty = (count == '0);
   assign o_full  = (count == fifo_cnt_t'(DEPTH));

   // Requests past the limits are dropped
   assign do_enq = i_enq & ~o_full;
   assign do_deq = i_deq & ~o_empty;

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= wr_ptr + 1'b1;        // Wraps at depth
         end
         if (do_deq) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         count <= '0;
      end else begin
         case ({do_enq, do_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // Both or neither
         endcase
      end
   end

   // Show-ahead head
   assign o_data  = mem[rd_ptr];
   assign o_count = count;

endmodule

// ==== run_merger.sv ====
module run_merger (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  merge_data_pkg::elem_t i_fifo_1,
   input  logic                  i_fifo_1_empty,
   input  merge_data_pkg::elem_t i_fifo_2,
   input  logic                  i_fifo_2_empty,
   input  logic                  i_fifo_out_ready,
   output logic                  o_fifo_1_read,
   output logic                  o_fifo_2_read,
   output logic                  o_out_fifo_write,
   output merge_data_pkg::elem_t o_data
);

   import merge_data_pkg::*;
   import merge_ctrl_pkg::*;

   // Input buffers
   elem_t      a_head;
   elem_t      b_head;
   logic       a_empty;
   logic       a_full;
   logic       b_empty;
   logic       b_full;
   logic       rd_a;
   logic       rd_b;

   // Control
   head_view_t heads;
   merge_cmd_t cmd;

   // Data stage and output side
   elem_t      stage_q;
   logic       stage_wr_q;
   logic       ready_q;
   logic       out_empty;
   fifo_cnt_t  out_count;
   logic       drain;

   // Pull from upstream whenever a word is there and the buffer has room
   assign rd_a = ~i_fifo_1_empty & ~a_full;
   assign rd_b = ~i_fifo_2_empty & ~b_full;

   assign o_fifo_1_read = rd_a;
   assign o_fifo_2_read = rd_b;

   merge_fifo buf_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_data  (i_fifo_1),
      .i_enq   (rd_a),
      .i_deq   (cmd.pop_a),
      .o_data  (a_head),
      .o_empty (a_empty),
      .o_full  (a_full),
      .o_count ()
   );

   merge_fifo buf_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_data  (i_fifo_2),
      .i_enq   (rd_b),
      .i_deq   (cmd.pop_b),
      .o_data  (b_head),
      .o_empty (b_empty),
      .o_full  (b_full),
      .o_count ()
   );

   assign heads.a_head  = a_head;
   assign heads.b_head  = b_head;
   assign heads.a_valid = ~a_empty;
   assign heads.b_valid = ~b_empty;

   merge_control ctrl (
      .i_heads     (heads),
      .i_out_count (out_count),
      .o_cmd       (cmd)
   );

   // Chosen head, written to the output buffer one cycle later
   always_ff @(posedge i_clk) begin
      if (cmd.emit) begin
         stage_q <= cmd.take_b ? b_head : a_head;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         stage_wr_q <= 1'b0;
         ready_q    <= 1'b0;
      end else begin
         stage_wr_q <= cmd.emit;          // One-cycle enqueue pulse
         ready_q    <= i_fifo_out_ready;  // Downstream ready, one cycle late
      end
   end

   // Stall in the control keeps this buffer from overflowing
   merge_fifo buf_out (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_data  (stage_q),
      .i_enq   (stage_wr_q),
      .i_deq   (drain),
      .o_data  (o_data),
      .o_empty (out_empty),
      .o_full  (),
      .o_count (out_count)
   );

   assign drain            = ready_q & ~out_empty;
   assign o_out_fifo_write = drain;

endmodule

// ==== run_merger_props.sv ====
module run_merger_props (
   input logic i_clk,
   input logic i_rst_n,
   input logic i_fifo_1_empty,
   input logic i_fifo_2_empty,
   input logic i_fifo_1_read,
   input logic i_fifo_2_read,
   input logic i_out_write,
   input logic i_out_empty
);

   timeunit 1ns;
   timeprecision 1ps;

   // Upstream is only read when it has a word
   a_read_1_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_fifo_1_read |-> !i_fifo_1_empty)
      else $error("side 1 read strobe while upstream empty");

   a_read_2_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_fifo_2_read |-> !i_fifo_2_empty)
      else $error("side 2 read strobe while upstream empty");

   a_write_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_out_write |-> !i_out_empty)
      else $error("output write while output buffer empty");

   // First cycle out of reset
   a_reset_release: assert property (@(posedge i_clk)
      $rose(i_rst_n) |-> (!i_out_write && !i_fifo_1_read && !i_fifo_2_read))
      else $error("strobe high in first cycle after reset");

   a_reset_write: assert property (@(posedge i_clk)
      !i_rst_n |=> !i_out_write)
      else $error("output write right after a reset cycle");

endmodule

bind run_merger run_merger_props props (
   .i_clk          (i_clk),
   .i_rst_n        (i_rst_n),
   .i_fifo_1_empty (i_fifo_1_empty),
   .i_fifo_2_empty (i_fifo_2_empty),
   .i_fifo_1_read  (o_fifo_1_read),
   .i_fifo_2_read  (o_fifo_2_read),
   .i_out_write    (o_out_fifo_write),
   .i_out_empty    (out_empty)
);

// ==== run_merger_tb.sv ====
module run_merger_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import merge_data_pkg::*;

   localparam int CLK_PERIOD    = 20;
   localparam int PHASE_TIMEOUT = 20000;   // Cycles per wait loop
   localparam int QUIET_CYCLES  = 40;

   logic  clk;
   logic  rst_n;
   elem_t fifo_1;
   logic  fifo_1_empty;
   elem_t fifo_2;
   logic  fifo_2_empty;
   logic  fifo_out_ready;
   logic  fifo_1_read;
   logic  fifo_2_read;
   logic  out_fifo_write;
   elem_t data_out;

   // Upstream FIFO contents and merged sequence expected downstream
   elem_t up_a[$];
   elem_t up_b[$];
   elem_t exp_q[$];

   int          errors;
   int          timeouts;
   int          words_in;
   int          words_out;
   int          zeros_out;
   int          pairs;
   int          ready_left;
   int          cycles;
   bit          prev_ready;
   bit          burst_mode;
   bit          aborted;
   int unsigned seed_val;
   string       test_name;

   run_merger dut (
      .i_clk            (clk),
      .i_rst_n          (rst_n),
      .i_fifo_1         (fifo_1),
      .i_fifo_1_empty   (fifo_1_empty),
      .i_fifo_2         (fifo_2),
      .i_fifo_2_empty   (fifo_2_empty),
      .i_fifo_out_ready (fifo_out_ready),
      .o_fifo_1_read    (fifo_1_read),
      .o_fifo_2_read    (fifo_2_read),
      .o_out_fifo_write (out_fifo_write),
      .o_data           (data_out)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // One sorted run per side, then the reference merge with ties to A
   task automatic add_pair(input int len_a, input int len_b);
      elem_t run_a[$];
      elem_t run_b[$];
      elem_t key;
      elem_t big;
      int    i;
      int    ia;
      int    ib;
      big = ($urandom_range(0, 3) == 0) ? elem_t'($urandom_range(32'h1000, 32'h7fff_0000)) : '0;
      key = big + elem_t'($urandom_range(1, 6));
      for (i = 0; i < len_a; i++) begin
         run_a.push_back(key);
         key = key + elem_t'($urandom_range(0, 3));   // Zero step gives duplicates
      end
      key = big + elem_t'($urandom_range(1, 6));
      for (i = 0; i < len_b; i++) begin
         run_b.push_back(key);
         key = key + elem_t'($urandom_range(0, 3));
      end
      foreach (run_a[j]) up_a.push_back(run_a[j]);
      foreach (run_b[j]) up_b.push_back(run_b[j]);
      up_a.push_back('0);
      up_b.push_back('0);
      ia = 0;
      ib = 0;
      while (ia < len_a || ib < len_b) begin
         if (ib >= len_b || (ia < len_a && run_a[ia] <= run_b[ib])) begin
            exp_q.push_back(run_a[ia]);
            ia = ia + 1;
         end else begin
            exp_q.push_back(run_b[ib]);
            ib = ib + 1;
         end
      end
      exp_q.push_back('0);   // Single terminator per pair
      pairs = pairs + 1;
   endtask

   task automatic load_pairs(input int n_pairs);
      int i;
      add_pair(0, 0);                          // Both runs empty
      add_pair(0, $urandom_range(1, 12));
      add_pair($urandom_range(1, 12), 0);
      for (i = 3; i < n_pairs; i++) begin
         add_pair($urandom_range(0, 12), $urandom_range(0, 12));
      end
   endtask

   function automatic bit model_idle();
      return (exp_q.size() == 0) && (up_a.size() == 0) && (up_b.size() == 0);
   endfunction

   task automatic clear_counters();
      words_in  = 0;
      words_out = 0;
      zeros_out = 0;
      pairs     = 0;
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout in %s: %s after %0d cycles", test_name, what, PHASE_TIMEOUT);
      timeouts = timeouts + 1;
      aborted  = 1'b1;
   endtask

   // Drive on the falling edge, sample a quarter period later
   task automatic step();
      elem_t exp;
      @(negedge clk);
      if (ready_left == 0) begin
         if (burst_mode && $urandom_range(0, 5) == 0) begin
            fifo_out_ready = 1'b0;
            ready_left     = $urandom_range(20, 60);
         end else begin
            fifo_out_ready = ($urandom_range(0, 2) != 0);
            ready_left     = $urandom_range(1, 4);
         end
      end
      ready_left   = ready_left - 1;
      fifo_1_empty = (up_a.size() == 0) || ($urandom_range(0, 3) == 0);
      fifo_2_empty = (up_b.size() == 0) || ($urandom_range(0, 3) == 0);
      fifo_1       = (up_a.size() != 0) ? up_a[0] : elem_t'($urandom);
      fifo_2       = (up_b.size() != 0) ? up_b[0] : elem_t'($urandom);
      #(CLK_PERIOD / 4);
      if (fifo_1_read) begin
         if (fifo_1_empty) begin
            $display("Side 1 read strobe while upstream reports empty in %s", test_name);
            errors = errors + 1;
         end else begin
            exp      = up_a.pop_front();
            words_in = words_in + 1;
         end
      end
      if (fifo_2_read) begin
         if (fifo_2_empty) begin
            $display("Side 2 read strobe while upstream reports empty in %s", test_name);
            errors = errors + 1;
         end else begin
            exp      = up_b.pop_front();
            words_in = words_in + 1;
         end
      end
      if (out_fifo_write) begin
         if (!prev_ready) begin
            $display("Output write in %s after a cycle with ready low", test_name);
            errors = errors + 1;
         end
         if (exp_q.size() == 0) begin
            $display("Unexpected output write in %s, word %h", test_name, data_out);
            errors = errors + 1;
         end else begin
            exp = exp_q.pop_front();
            if (data_out !== exp) begin
               $display("ERROR %s: output word %0d expected %h actual %h",
                        test_name, words_out, exp, data_out);
               errors = errors + 1;
            end
         end
         words_out = words_out + 1;
         if (data_out == '0) zeros_out = zeros_out + 1;
      end
      prev_ready = fifo_out_ready;
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n          = 1'b0;
      fifo_1_empty   = 1'b1;
      fifo_2_empty   = 1'b1;
      fifo_1         = '0;
      fifo_2         = '0;
      fifo_out_ready = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;   // Upstream stays empty through the first cycle
      #(CLK_PERIOD / 4);
      if (out_fifo_write !== 1'b0 || fifo_1_read !== 1'b0 || fifo_2_read !== 1'b0) begin
         $display("ERROR reset: strobes write/read1/read2 expected 000 actual %b%b%b",
                  out_fifo_write, fifo_1_read, fifo_2_read);
         errors = errors + 1;
      end
      prev_ready = 1'b0;
      ready_left = 0;
   endtask

   task automatic check_counts();
      if (words_out != words_in - pairs) begin
         $display("ERROR %s: word count expected %0d actual %0d",
                  test_name, words_in - pairs, words_out);
         errors = errors + 1;
      end
      if (zeros_out != pairs) begin
         $display("ERROR %s: terminator count expected %0d actual %0d",
                  test_name, pairs, zeros_out);
         errors = errors + 1;
      end
   endtask

   task automatic run_phase(input string name, input int n_pairs, input bit bursts);
      int n;
      test_name  = name;
      burst_mode = bursts;
      clear_counters();
      load_pairs(n_pairs);
      n = 0;
      while (!model_idle() && n < PHASE_TIMEOUT) begin
         step();
         n = n + 1;
      end
      if (!model_idle()) begin
         report_timeout("merged output incomplete");
      end else begin
         repeat (QUIET_CYCLES) step();   // Any write here is extra
         check_counts();
      end
   endtask

   initial begin
      seed_val       = $urandom(91641);
      errors         = 0;
      timeouts       = 0;
      aborted        = 1'b0;
      burst_mode     = 1'b0;
      prev_ready     = 1'b0;
      ready_left     = 0;
      rst_n          = 1'b0;
      fifo_1         = '0;
      fifo_2         = '0;
      fifo_1_empty   = 1'b1;
      fifo_2_empty   = 1'b1;
      fifo_out_ready = 1'b0;
      test_name      = "reset";
      clear_counters();

      apply_reset();
      run_phase("merge_random", 40, 1'b0);
      if (!aborted) run_phase("merge_backpressure", 40, 1'b1);

      if (!aborted) begin
         // Stop partway through a load, reset, then start over
         test_name  = "mid_run_reset";
         burst_mode = 1'b1;
         clear_counters();
         load_pairs(20);
         cycles = 0;
         while (words_out < 10 && cycles < PHASE_TIMEOUT) begin
            step();
            cycles = cycles + 1;
         end
         if (words_out < 10) begin
            report_timeout("no output before reset");
         end else begin
            apply_reset();
            up_a.delete();
            up_b.delete();
            exp_q.delete();
         end
      end
      if (!aborted) run_phase("merge_after_reset", 30, 1'b1);

      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the run_merger testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module run_merger_tb \
   -f flist.f \
   -o run_merger_sim

./obj_dir/run_merger_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
   echo "run_sim.sh: testbench reported failure"
   exit 1
fi

echo "run_sim.sh: testbench reported no failure"
exit 0
